/* compile.f */
logic/foc_types_pkg.sv
logic/foc_trig_pkg.sv
logic/ab_stream_if.sv
logic/current_mux.sv
logic/clarke_transform.sv
logic/park_transform.sv
logic/muxed_park_transform.sv
logic/current_loop.sv
testbench/current_loop_tb.sv

/* logic/ab_stream_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface ab_stream_if;
    import foc_types_pkg::*;
    import foc_trig_pkg::*;

    current_t a;
    current_t b;
    theta_t   theta;
    path_t    channel;
    logic     valid;
    logic     ready;

    modport source (
        output a, b, theta, channel, valid,
        input  ready
    );

    modport sink (
        input  a, b, theta, channel, valid,
        output ready
    );

endinterface

`default_nettype wire

/* logic/clarke_transform.sv */
`timescale 1ns/1ps
`default_nettype none

module clarke_transform (
        input  wire                        clk,
        input  wire                        reset,
        input  wire foc_trig_pkg::theta_t  theta,
        ab_stream_if.sink                  uv,
        ab_stream_if.source                ab
    );
    import foc_types_pkg::*;
    import foc_trig_pkg::*;

    localparam logic signed [17:0] COEF = 18'(INV_SQRT3_Q15);

    logic signed [17:0] sum_uv;
    logic signed [35:0] beta_full;
    logic signed [35:0] beta_rnd;
    current_t           beta;

    current_t ab_a;
    current_t ab_b;
    theta_t   ab_theta;
    logic     ab_valid;
    logic     accept;

    // beta = (U + 2V) / sqrt(3)
    assign sum_uv = 18'(uv.a) + 18'(uv.b) + 18'(uv.b);
    assign beta_full = sum_uv * COEF;
    assign beta_rnd = (beta_full + 36'(Q15_HALF)) >>> Q15_SHIFT;

    always_comb begin
        if (beta_rnd > 36'(Q15_MAX))
            beta = current_t'(Q15_MAX);
        else if (beta_rnd < 36'(Q15_MIN))
            beta = current_t'(Q15_MIN);
        else
            beta = current_t'(beta_rnd);
    end

    // Empty or draining this edge
    assign uv.ready = !ab_valid || ab.ready;
    assign accept = uv.valid && uv.ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            ab_valid <= 1'b0;
        else if (uv.ready)
            ab_valid <= uv.valid;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ab_a <= uv.a; // alpha is U itself
            ab_b <= beta;
            ab_theta <= theta; // Angle that belongs to this pair
        end
    end

    assign ab.a = ab_a;
    assign ab.b = ab_b;
    assign ab.theta = ab_theta;
    assign ab.channel = MEAS_PATH;
    assign ab.valid = ab_valid;

endmodule

`default_nettype wire

/* logic/current_loop.sv */
`timescale 1ns/1ps
`default_nettype none

module current_loop #(
        parameter int OUT_LIMIT = 30000
    ) (
        input  wire                          clk,
        input  wire                          reset,
        input  wire foc_types_pkg::current_t current_u_data,
        input  wire                          current_u_valid,
        input  wire foc_types_pkg::current_t current_v_data,
        input  wire                          current_v_valid,
        input  wire foc_trig_pkg::theta_t    theta,
        output wire foc_types_pkg::current_t meas_d_data,
        output wire foc_types_pkg::current_t meas_q_data,
        output wire                          meas_valid,
        input  wire foc_types_pkg::voltage_t volt_d_data,
        input  wire foc_types_pkg::voltage_t volt_q_data,
        input  wire                          volt_valid,
        output wire                          volt_ready,
        output wire foc_types_pkg::voltage_t volt_a_data,
        output wire foc_types_pkg::voltage_t volt_b_data,
        output wire                          volt_ab_valid,
        input  wire                          volt_ab_ready
    );

    ab_stream_if mux_to_clarke ();
    ab_stream_if clarke_to_park ();

    // Pairs independently arriving U and V samples
    current_mux imux (
        .clk(clk),
        .reset(reset),
        .u_data(current_u_data),
        .u_valid(current_u_valid),
        .v_data(current_v_data),
        .v_valid(current_v_valid),
        .pair(mux_to_clarke)
    );

    clarke_transform clarke (
        .clk(clk),
        .reset(reset),
        .theta(theta), // Sampled as the pair is taken
        .uv(mux_to_clarke),
        .ab(clarke_to_park)
    );

    // Shared rotator for both directions
    muxed_park_transform #(
        .OUT_LIMIT(OUT_LIMIT)
    ) park (
        .clk(clk),
        .reset(reset),
        .meas_in(clarke_to_park),
        .cmd_d(volt_d_data),
        .cmd_q(volt_q_data),
        .cmd_valid(volt_valid),
        .cmd_ready(volt_ready),
        .meas_d(meas_d_data),
        .meas_q(meas_q_data),
        .meas_valid(meas_valid),
        .volt_a(volt_a_data),
        .volt_b(volt_b_data),
        .volt_valid(volt_ab_valid),
        .volt_ready(volt_ab_ready)
    );

endmodule

`default_nettype wire

/* logic/current_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module current_mux (
        input  wire                       clk,
        input  wire                       reset,
        input  wire foc_types_pkg::current_t u_data,
        input  wire                       u_valid,
        input  wire foc_types_pkg::current_t v_data,
        input  wire                       v_valid,
        ab_stream_if.source               pair
    );
    import foc_types_pkg::*;

    current_t u_hold;
    current_t v_hold;
    logic     u_avail;
    logic     v_avail;
    logic     take;

    assign take = pair.valid && pair.ready;

    // A sample on the taking edge sets its flag again
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            u_avail <= 1'b0;
            v_avail <= 1'b0;
        end else begin
            if (u_valid) u_avail <= 1'b1;
            else if (take) u_avail <= 1'b0;
            if (v_valid) v_avail <= 1'b1;
            else if (take) v_avail <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (u_valid) u_hold <= u_data; // Latest sample wins
        if (v_valid) v_hold <= v_data;
    end

    assign pair.a = u_hold;
    assign pair.b = v_hold;
    assign pair.theta = '0;
    assign pair.channel = MEAS_PATH;
    assign pair.valid = u_avail && v_avail;

    // Stalled pair holds unless a fresh sample replaces it
    a_pair_hold: assert property (@(posedge clk) disable iff (reset)
        pair.valid && !pair.ready && !u_valid && !v_valid
        |=> pair.valid && $stable(pair.a) && $stable(pair.b))
        else $error("current pair changed while stalled");

endmodule

`default_nettype wire

/* logic/foc_trig_pkg.sv */
`default_nettype none

package foc_trig_pkg;

    // 256 steps per electrical turn
    typedef logic [7:0] theta_t;

    typedef logic signed [15:0] sine_t;

    // sin((i + 0.5) * 90deg / 64) * 32767
    localparam sine_t SINE_QUARTER [0:63] = '{
        16'sd402,   16'sd1206,  16'sd2009,  16'sd2811,
        16'sd3612,  16'sd4410,  16'sd5205,  16'sd5998,
        16'sd6786,  16'sd7571,  16'sd8351,  16'sd9126,
        16'sd9896,  16'sd10659, 16'sd11417, 16'sd12167,
        16'sd12910, 16'sd13645, 16'sd14372, 16'sd15090,
        16'sd15800, 16'sd16499, 16'sd17189, 16'sd17869,
        16'sd18537, 16'sd19195, 16'sd19841, 16'sd20475,
        16'sd21096, 16'sd21705, 16'sd22301, 16'sd22884,
        16'sd23452, 16'sd24007, 16'sd24547, 16'sd25072,
        16'sd25582, 16'sd26077, 16'sd26556, 16'sd27019,
        16'sd27466, 16'sd27896, 16'sd28310, 16'sd28706,
        16'sd29085, 16'sd29447, 16'sd29791, 16'sd30117,
        16'sd30424, 16'sd30714, 16'sd30985, 16'sd31237,
        16'sd31470, 16'sd31685, 16'sd31880, 16'sd32057,
        16'sd32213, 16'sd32351, 16'sd32469, 16'sd32567,
        16'sd32646, 16'sd32705, 16'sd32745, 16'sd32765
    };

    function automatic sine_t sin_q15(input theta_t theta);
        logic [5:0] idx;
        sine_t mag;
        // Second and fourth quadrants run the table backwards
        idx = theta[6] ? ~theta[5:0] : theta[5:0];
        mag = SINE_QUARTER[idx];
        return theta[7] ? -mag : mag; // Lower half-turn is negative
    endfunction

    function automatic sine_t cos_q15(input theta_t theta);
        theta_t shifted;
        shifted = theta + theta_t'(64); // Quarter turn ahead
        return sin_q15(shifted);
    endfunction

endpackage

`default_nettype wire

/* logic/foc_types_pkg.sv */
`default_nettype none

package foc_types_pkg;

    // Q15 phase and alpha/beta currents
    typedef logic signed [15:0] current_t;

    // d/q command in, alpha/beta voltage out
    typedef logic signed [15:0] voltage_t;

    // Full 16x16 product and the sum of two products
    typedef logic signed [31:0] product_t;
    typedef logic signed [32:0] acc_t;

    // Rotator item kind
    typedef logic [0:0] path_t;

    localparam path_t MEAS_PATH = 1'b0; // forward Park
    localparam path_t CMD_PATH = 1'b1;  // inverse Park

    localparam int Q15_SHIFT = 15;
    localparam int Q15_HALF = 1 << (Q15_SHIFT - 1); // Rounding offset
    localparam int Q15_MAX = 32767;
    localparam int Q15_MIN = -32768;

    // 1/sqrt(3) in Q15
    localparam int INV_SQRT3_Q15 = 18919;

endpackage

`default_nettype wire

/* logic/muxed_park_transform.sv */
`timescale 1ns/1ps
`default_nettype none

module muxed_park_transform #(
        parameter int OUT_LIMIT = 30000
    ) (
        input  wire                          clk,
        input  wire                          reset,
        ab_stream_if.sink                    meas_in,
        input  wire foc_types_pkg::voltage_t cmd_d,
        input  wire foc_types_pkg::voltage_t cmd_q,
        input  wire                          cmd_valid,
        output logic                         cmd_ready,
        output foc_types_pkg::current_t      meas_d,
        output foc_types_pkg::current_t      meas_q,
        output logic                         meas_valid,
        output foc_types_pkg::voltage_t      volt_a,
        output foc_types_pkg::voltage_t      volt_b,
        output logic                         volt_valid,
        input  wire                          volt_ready
    );
    import foc_types_pkg::*;
    import foc_trig_pkg::*;

    theta_t last_theta;
    logic   out_is_meas;

    ab_stream_if park_in ();
    ab_stream_if park_out ();

    park_transform #(
        .OUT_LIMIT(OUT_LIMIT)
    ) park (
        .clk(clk),
        .reset(reset),
        .in(park_in),
        .out(park_out)
    );

    // Commands rotate by the most recent measured angle
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            last_theta <= '0;
        else if (meas_in.valid && meas_in.ready)
            last_theta <= meas_in.theta;
    end

    // Measurement first
    assign park_in.valid = meas_in.valid || cmd_valid;
    assign park_in.channel = meas_in.valid ? MEAS_PATH : CMD_PATH;
    assign park_in.a = meas_in.valid ? meas_in.a : cmd_d;
    assign park_in.b = meas_in.valid ? meas_in.b : cmd_q;
    assign park_in.theta = meas_in.valid ? meas_in.theta : last_theta;
    assign meas_in.ready = park_in.ready;
    assign cmd_ready = !meas_in.valid && park_in.ready;

    // Results split by channel; measurement side never stalls
    assign out_is_meas = (park_out.channel == MEAS_PATH);
    assign meas_d = park_out.a;
    assign meas_q = park_out.b;
    assign meas_valid = park_out.valid && out_is_meas;
    assign volt_a = park_out.a;
    assign volt_b = park_out.b;
    assign volt_valid = park_out.valid && !out_is_meas;
    assign park_out.ready = out_is_meas || volt_ready;

    // Blocked command result holds
    a_volt_hold: assert property (@(posedge clk) disable iff (reset)
        volt_valid && !volt_ready
        |=> volt_valid && $stable(volt_a) && $stable(volt_b))
        else $error("command result changed while blocked");

endmodule

`default_nettype wire

/* logic/park_transform.sv */
`timescale 1ns/1ps
`default_nettype none

module park_transform #(
        parameter int OUT_LIMIT = 30000
    ) (
        input  wire         clk,
        input  wire         reset,
        ab_stream_if.sink   in,
        ab_stream_if.source out
    );
    import foc_types_pkg::*;
    import foc_trig_pkg::*;

    sine_t    sin_v;
    sine_t    cos_v;
    logic     advance;

    // Stage one
    product_t p_acos;
    product_t p_bsin;
    product_t p_asin;
    product_t p_bcos;
    path_t    s1_channel;
    theta_t   s1_theta;
    logic     s1_valid;

    // Stage two
    acc_t     acc_x;
    acc_t     acc_y;
    int       limit;
    current_t s2_x;
    current_t s2_y;
    path_t    s2_channel;
    theta_t   s2_theta;
    logic     s2_valid;

    function automatic current_t round_sat(input acc_t acc, input int lim);
        acc_t r;
        r = (acc + acc_t'(Q15_HALF)) >>> Q15_SHIFT;
        if (r > acc_t'(lim)) return current_t'(lim);
        if (r < -acc_t'(lim)) return current_t'(-lim);
        return current_t'(r);
    endfunction

    assign sin_v = sin_q15(in.theta);
    assign cos_v = cos_q15(in.theta);

    // Whole pipe freezes on a blocked output
    assign advance = !(s2_valid && !out.ready);
    assign in.ready = advance;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= in.valid;
            s2_valid <= s1_valid;
        end
    end

    always_comb begin
        if (s1_channel == MEAS_PATH) begin
            acc_x = acc_t'(p_acos) + acc_t'(p_bsin); // d
            acc_y = acc_t'(p_bcos) - acc_t'(p_asin); // q
        end else begin
            acc_x = acc_t'(p_acos) - acc_t'(p_bsin); // alpha
            acc_y = acc_t'(p_asin) + acc_t'(p_bcos); // beta
        end
    end

    // Measurements only clip to the Q15 range
    assign limit = (s1_channel == MEAS_PATH) ? Q15_MAX : OUT_LIMIT;

    always_ff @(posedge clk) begin
        if (advance) begin
            p_acos <= in.a * cos_v;
            p_bsin <= in.b * sin_v;
            p_asin <= in.a * sin_v;
            p_bcos <= in.b * cos_v;
            s1_channel <= in.channel;
            s1_theta <= in.theta;
            s2_x <= round_sat(acc_x, limit);
            s2_y <= round_sat(acc_y, limit);
            s2_channel <= s1_channel;
            s2_theta <= s1_theta;
        end
    end

    assign out.a = s2_x;
    assign out.b = s2_y;
    assign out.channel = s2_channel;
    assign out.theta = s2_theta;
    assign out.valid = s2_valid;

    a_two_stage: assert property (@(posedge clk) disable iff (reset)
        $rose(out.valid) |-> $past(in.valid && in.ready, 2))
        else $error("park output without matching input");

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module current_loop_tb \
    -Mdir obj_dir -o current_loop_sim -f compile.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/current_loop_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q -F '** PASS **'; then
    exit 0
fi
echo "Pass message not found"
exit 1

/* testbench/current_loop_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module current_loop_tb;
    import foc_types_pkg::*;
    import foc_trig_pkg::*;

    localparam int OUT_LIMIT = 30000;
    localparam int MAX_CYCLES = 4000; // 20 items per test at about 30 cycles, plus margin

    logic     clk;
    logic     reset;
    current_t u_data;
    logic     u_valid;
    current_t v_data;
    logic     v_valid;
    theta_t   theta;
    current_t meas_d;
    current_t meas_q;
    logic     meas_valid;
    voltage_t volt_d;
    voltage_t volt_q;
    logic     volt_valid;
    logic     volt_ready;
    voltage_t volt_a;
    voltage_t volt_b;
    logic     volt_ab_valid;
    logic     volt_ab_ready;

    int          cycle = 0;
    int          errors = 0;
    int          checks = 0;
    logic [31:0] lfsr = 32'hfc0f;
    theta_t      meas_theta = '0; // Angle of the latest measurement

    // Results seen at the outputs, with the cycle they appeared in
    current_t md_q[$];
    current_t mq_q[$];
    int       mc_q[$];
    voltage_t va_q[$];
    voltage_t vb_q[$];
    int       vc_q[$];

    current_loop #(
        .OUT_LIMIT(OUT_LIMIT)
    ) dut (
        .clk(clk),
        .reset(reset),
        .current_u_data(u_data),
        .current_u_valid(u_valid),
        .current_v_data(v_data),
        .current_v_valid(v_valid),
        .theta(theta),
        .meas_d_data(meas_d),
        .meas_q_data(meas_q),
        .meas_valid(meas_valid),
        .volt_d_data(volt_d),
        .volt_q_data(volt_q),
        .volt_valid(volt_valid),
        .volt_ready(volt_ready),
        .volt_a_data(volt_a),
        .volt_b_data(volt_b),
        .volt_ab_valid(volt_ab_valid),
        .volt_ab_ready(volt_ab_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic current_t rand_sample();
        return current_t'(int'(take_bits(15) % 32001) - 16000); // Within +-16000
    endfunction

    function automatic int round_q15(input longint x);
        return int'((x + longint'(Q15_HALF)) >>> Q15_SHIFT);
    endfunction

    function automatic int clamp(input int x, input int lim);
        if (x > lim)
            return lim;
        if (x < -lim)
            return -lim;
        return x;
    endfunction

    function automatic current_t expected_beta(input current_t u, input current_t v);
        longint s;
        s = (longint'(u) + 2 * longint'(v)) * INV_SQRT3_Q15;
        return current_t'(clamp(round_q15(s), Q15_MAX));
    endfunction

    task automatic expected_rotation(input longint a, input longint b, input theta_t th,
                                     input path_t path, output int x, output int y);
        longint s;
        longint c;
        s = longint'(sin_q15(th));
        c = longint'(cos_q15(th));
        if (path == MEAS_PATH) begin
            x = round_q15(a * c + b * s);
            y = round_q15(b * c - a * s);
        end else begin
            x = clamp(round_q15(a * c - b * s), OUT_LIMIT);
            y = clamp(round_q15(a * s + b * c), OUT_LIMIT);
        end
    endtask

    task automatic check_current(input string name, input current_t exp, input current_t act);
        int diff;
        diff = int'(exp) - int'(act);
        checks++;
        if (diff > 2 || diff < -2) begin
            errors++;
            $display("ERROR t=%0t %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_voltage(input string name, input voltage_t exp, input voltage_t act);
        int diff;
        diff = int'(exp) - int'(act);
        checks++;
        if (diff > 2 || diff < -2) begin
            errors++;
            $display("ERROR t=%0t %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        checks++;
        if (exp != act) begin
            errors++;
            $display("ERROR t=%0t %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR t=%0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("Failure at %0t: %s", $time, what);
    endtask

    // order 0 is U first, 1 is V first, 2 is both at once
    task automatic send_pair(input current_t u, input current_t v, input theta_t th,
                             input int order, output int start);
        @(posedge clk);
        theta <= th;
        if (order != 1) begin
            u_data <= u;
            u_valid <= 1'b1;
        end
        if (order != 0) begin
            v_data <= v;
            v_valid <= 1'b1;
        end
        if (order != 2) begin
            @(posedge clk);
            u_valid <= (order == 1);
            v_valid <= (order == 0);
            if (order == 0)
                v_data <= v;
            else
                u_data <= u;
        end
        @(negedge clk);
        start = cycle; // Completing edge is the next one
        @(posedge clk);
        u_valid <= 1'b0;
        v_valid <= 1'b0;
    endtask

    task automatic measure(input current_t u, input current_t v, input theta_t th,
                           input int order, input logic timed);
        int       start;
        int       seen;
        int       exp_d;
        int       exp_q;
        current_t beta;
        send_pair(u, v, th, order, start);
        beta = expected_beta(u, v);
        expected_rotation(u, beta, th, MEAS_PATH, exp_d, exp_q);
        meas_theta = th;
        while (md_q.size() == 0)
            @(posedge clk);
        check_current("meas_d_data", current_t'(exp_d), md_q.pop_front());
        check_current("meas_q_data", current_t'(exp_q), mq_q.pop_front());
        seen = mc_q.pop_front();
        if (timed)
            check_latency("meas_valid latency", 4, seen - start);
        repeat (4) @(posedge clk);
        if (md_q.size() != 0) begin
            report_failure("more than one measurement for a single U/V pair");
            md_q.delete();
            mq_q.delete();
            mc_q.delete();
        end
    endtask

    task automatic send_command(input voltage_t d, input voltage_t q, output int start);
        @(posedge clk);
        volt_d <= d;
        volt_q <= q;
        volt_valid <= 1'b1;
        @(negedge clk);
        while (!volt_ready)
            @(negedge clk);
        start = cycle;
        @(posedge clk);
        volt_valid <= 1'b0;
    endtask

    task automatic idle_after_reset();
        repeat (20) begin
            @(negedge clk);
            check_flag("meas_valid", 1'b0, meas_valid);
            check_flag("volt_ab_valid", 1'b0, volt_ab_valid);
            check_flag("volt_ready", 1'b1, volt_ready);
        end
    endtask

    task automatic measure_random_pairs();
        current_t u;
        current_t v;
        theta_t   th;
        int       order;
        for (int i = 0; i < 20; i++) begin
            u = rand_sample();
            v = rand_sample();
            th = theta_t'(take_bits(8));
            order = int'(take_bits(2) % 3);
            measure(u, v, th, order, 1'b1);
        end
    endtask

    task automatic replace_held_sample();
        @(posedge clk);
        u_data <= rand_sample(); // Overwritten before V arrives
        u_valid <= 1'b1;
        measure(rand_sample(), rand_sample(), theta_t'(take_bits(8)), 0, 1'b1);
    endtask

    task automatic rotate_commands();
        voltage_t d;
        voltage_t q;
        int       start;
        int       exp_a;
        int       exp_b;
        measure(rand_sample(), rand_sample(), theta_t'(take_bits(8)), 2, 1'b1);
        for (int i = 0; i < 20; i++) begin
            d = voltage_t'(take_bits(16)); // Full range, often past OUT_LIMIT
            q = voltage_t'(take_bits(16));
            send_command(d, q, start);
            expected_rotation(d, q, meas_theta, CMD_PATH, exp_a, exp_b);
            while (va_q.size() == 0)
                @(posedge clk);
            check_voltage("volt_a_data", voltage_t'(exp_a), va_q.pop_front());
            check_voltage("volt_b_data", voltage_t'(exp_b), vb_q.pop_front());
            check_latency("volt_ab_valid latency", 2, vc_q.pop_front() - start);
        end
    endtask

    task automatic stall_and_priority();
        voltage_t    cd[12];
        voltage_t    cq[12];
        int          ea[12];
        int          eb[12];
        current_t    mu[8];
        current_t    mv[8];
        logic        ready_pattern[160];
        logic [31:0] bits;
        int          k;
        int          len;
        int          start_cmd;
        // One angle for the whole test keeps the command angle known
        measure(rand_sample(), rand_sample(), theta_t'(take_bits(8)), 2, 1'b1);
        for (int i = 0; i < 12; i++) begin
            cd[i] = voltage_t'(take_bits(16));
            cq[i] = voltage_t'(take_bits(16));
            expected_rotation(cd[i], cq[i], meas_theta, CMD_PATH, ea[i], eb[i]);
        end
        for (int i = 0; i < 8; i++) begin
            mu[i] = rand_sample();
            mv[i] = rand_sample();
        end
        k = 0;
        while (k < 160) begin
            bits = take_bits(1);
            len = int'(take_bits(3)) + 1;
            for (int j = 0; j < len && k < 160; j++) begin
                ready_pattern[k] = bits[0];
                k++;
            end
        end
        fork
            begin
                for (int i = 0; i < 12; i++)
                    send_command(cd[i], cq[i], start_cmd);
            end
            begin
                for (int i = 0; i < 8; i++)
                    measure(mu[i], mv[i], meas_theta, i % 3, 1'b0);
            end
            begin
                for (int i = 0; i < 160; i++) begin
                    @(posedge clk);
                    volt_ab_ready <= ready_pattern[i];
                end
                @(posedge clk);
                volt_ab_ready <= 1'b1;
            end
        join
        while (va_q.size() < 12)
            @(posedge clk);
        repeat (4) @(posedge clk);
        if (va_q.size() != 12)
            report_failure("command results do not match the number of commands");
        for (int i = 0; i < 12 && va_q.size() > 0; i++) begin
            check_voltage("volt_a_data", voltage_t'(ea[i]), va_q.pop_front());
            check_voltage("volt_b_data", voltage_t'(eb[i]), vb_q.pop_front());
        end
        vc_q.delete();
    endtask

    // Output monitor, priority check and cycle limit
    initial begin
        while (cycle < MAX_CYCLES) begin
            @(negedge clk);
            if (meas_valid) begin
                md_q.push_back(meas_d);
                mq_q.push_back(meas_q);
                mc_q.push_back(cycle);
            end
            if (volt_ab_valid && volt_ab_ready) begin
                va_q.push_back(volt_a);
                vb_q.push_back(volt_b);
                vc_q.push_back(cycle);
            end
            if (!reset && dut.clarke_to_park.valid)
                check_flag("volt_ready", 1'b0, volt_ready); // Measurement waiting
        end
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        reset = 1'b1;
        u_data = '0;
        u_valid = 1'b0;
        v_data = '0;
        v_valid = 1'b0;
        theta = '0;
        volt_d = '0;
        volt_q = '0;
        volt_valid = 1'b0;
        volt_ab_ready = 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        idle_after_reset();
        measure_random_pairs();
        replace_held_sample();
        rotate_commands();
        stall_and_priority();
        repeat (5) @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire
